// File: common/imul_pkg.sv
/*
 * shared widths, types and FSM encoding for the iterative signed multiplier
 * every RTL file of the unit pulls these in with a wildcard import
 */

package imul_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // operand and product widths, fixed at 32 x 32 -> 64
  localparam int op_w   = 32;
  localparam int prod_w = 2 * op_w;

  // one shift-and-add step per multiplier bit
  localparam int step_n = op_w;
  localparam int cnt_w  = $clog2(step_n);

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------

  typedef logic [op_w-1:0]   operand_t;
  typedef logic [prod_w-1:0] product_t;
  typedef logic [cnt_w-1:0]  step_cnt_t;

  // count value seen during the final step
  localparam step_cnt_t last_step = step_cnt_t'(step_n - 1);

  // captured request as sign-magnitude, 65 bits
  typedef struct packed {
    operand_t mag_a;
    operand_t mag_b;
    logic     neg;    // exactly one operand was negative
  } mul_opnd_t;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_calc,
    st_done
  } mul_state_t;

endpackage

// File: rtl/imul_req_stage.sv
/*
 * input side of the multiplier, converts an accepted request into
 * two unsigned magnitudes plus the sign of the product
 */

`timescale 1ns/1ps

module imul_req_stage
  import imul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      accept,
  input  operand_t  req_a,
  input  operand_t  req_b,
  output mul_opnd_t opnd
);

  logic     sign_a;
  logic     sign_b;
  operand_t mag_a;
  operand_t mag_b;

  // sign bits of the raw operands
  assign sign_a = req_a[op_w-1];
  assign sign_b = req_b[op_w-1];

  // two's complement magnitude
  // 32'h8000_0000 maps onto itself, which reads as 2^31 unsigned
  assign mag_a = sign_a ? (~req_a + operand_t'(1)) : req_a;
  assign mag_b = sign_b ? (~req_b + operand_t'(1)) : req_b;

  // capture register, only written on the handshake cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      opnd <= '0;
    end else if (accept) begin
      opnd.mag_a <= mag_a;
      opnd.mag_b <= mag_b;
      // negative product when the signs differ
      opnd.neg   <= sign_a ^ sign_b;
    end
  end

endmodule

// File: imul_iter/imul_iter_ctrl.sv
/*
 * control FSM for the iterative multiplier
 * sequences accept, load, 32 steps and the hand-off to the response stage
 */

`timescale 1ns/1ps

module imul_iter_ctrl
  import imul_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  input  logic resp_val,
  output logic accept,
  output logic load,
  output logic step,
  output logic hand_off
);

  mul_state_t state;
  mul_state_t state_next;
  step_cnt_t  step_cnt;

  // ------------------------------------------------------------------------
  // output decode
  // ------------------------------------------------------------------------

  // only idle takes a new request, so the captured operands stay put
  // until the product has left for the response stage
  assign req_rdy  = (state == st_idle);
  assign accept   = req_rdy & req_val;
  assign load     = (state == st_load);
  assign step     = (state == st_calc);
  // wait in done while the response slot is still occupied
  assign hand_off = (state == st_done) & ~resp_val;

  // ------------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_load;
      st_load: state_next = st_calc;
      st_calc: if (step_cnt == last_step) state_next = st_done;
      st_done: if (hand_off) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // step counter, cleared while loading and advanced once per step
  always_ff @(posedge clk) begin
    if (reset) begin
      step_cnt <= '0;
    end else if (load) begin
      step_cnt <= '0;
    end else if (step) begin
      step_cnt <= step_cnt + step_cnt_t'(1);
    end
  end

endmodule

// File: imul_iter/imul_iter_dpath.sv
/*
 * shift-and-add datapath forming the unsigned product of two magnitudes
 * loaded once, then stepped 32 times by the control FSM
 */

`timescale 1ns/1ps

module imul_iter_dpath
  import imul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      load,
  input  logic      step,
  input  mul_opnd_t opnd,
  output product_t  prod_mag
);

  product_t mcand;    // multiplicand, moves left one bit per step
  operand_t mplier;   // multiplier, moves right one bit per step
  product_t acc;      // running partial sum
  product_t acc_next;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
    end else if (load) begin
      // zero-extend a into the upper half
      mcand  <= {{(prod_w - op_w){1'b0}}, opnd.mag_a};
      mplier <= opnd.mag_b;
      acc    <= '0;
    end else if (step) begin
      acc    <= acc_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // final after the 32nd step, no sign handling here
  assign prod_mag = acc;

endmodule

// File: rtl/imul_resp_stage.sv
/*
 * output side of the multiplier, applies the sign to the magnitude
 * and keeps the response stable until the consumer takes it
 */

`timescale 1ns/1ps

module imul_resp_stage
  import imul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     hand_off,
  input  logic     neg,
  input  product_t prod_mag,
  input  logic     resp_rdy,
  output product_t resp_product,
  output logic     resp_val
);

  product_t prod_signed;

  // negate in two's complement for a negative result
  assign prod_signed = neg ? (~prod_mag + product_t'(1)) : prod_mag;

  // ------------------------------------------------------------------------
  // response slot
  // ------------------------------------------------------------------------

  // hand_off only arrives while the slot is empty,
  // so it never collides with a delivery
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (hand_off) begin
      resp_val <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // product holds its value under back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_product <= '0;
    end else if (hand_off) begin
      resp_product <= prod_signed;
    end
  end

endmodule

// File: rtl/imul_top.sv
/*
 * signed 32 x 32 -> 64 iterative multiplier with val/rdy on both sides
 * up to two multiplies in flight, one computing and one in the response slot
 */

`timescale 1ns/1ps

module imul_top
  import imul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  operand_t req_a,
  input  operand_t req_b,
  input  logic     req_val,
  output logic     req_rdy,
  output product_t resp_product,
  output logic     resp_val,
  input  logic     resp_rdy
);

  logic      accept;
  logic      load;
  logic      step;
  logic      hand_off;
  mul_opnd_t opnd;
  product_t  prod_mag;

  // sign-magnitude capture of the request
  imul_req_stage req_stage (
    .clk    (clk),
    .reset  (reset),
    .accept (accept),
    .req_a  (req_a),
    .req_b  (req_b),
    .opnd   (opnd)
  );

  // sequencing, also owns req_rdy
  imul_iter_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .accept   (accept),
    .load     (load),
    .step     (step),
    .hand_off (hand_off)
  );

  // unsigned shift-and-add core
  imul_iter_dpath dpath (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .opnd     (opnd),
    .prod_mag (prod_mag)
  );

  // sign fix-up and the response register
  imul_resp_stage resp_stage (
    .clk          (clk),
    .reset        (reset),
    .hand_off     (hand_off),
    .neg          (opnd.neg),
    .prod_mag     (prod_mag),
    .resp_rdy     (resp_rdy),
    .resp_product (resp_product),
    .resp_val     (resp_val)
  );

endmodule

// File: tb/imul_tb.sv
/*
 * self-checking testbench for the iterative signed multiplier
 * directed corners, random operands, then random response back-pressure
 */

`timescale 1ns/1ps

module imul_tb
  import imul_pkg::*;
();

  localparam int          clk_period   = 8;
  localparam int          reset_cycles = 5;
  localparam logic [31:0] seed         = 32'h7295_7ff0;
  localparam int          n_directed   = 8;
  localparam int          n_random     = 200;
  localparam int          n_backpr     = 60;
  localparam int          n_ops        = n_directed + n_random + n_backpr;
  localparam int          cycle_limit  = 40 * n_ops * 4 + 200;
  // accept edge to the edge that sets resp_val
  localparam int          latency      = 34;

  logic     clk;
  logic     reset;
  operand_t req_a;
  operand_t req_b;
  logic     req_val;
  logic     req_rdy;
  product_t resp_product;
  logic     resp_val;
  logic     resp_rdy;

  // pending requests as {a, b}, expected products and accept times
  logic [2*op_w-1:0] req_q[$];
  product_t          exp_q[$];
  time               acc_t_q[$];

  logic [31:0] lcg_state;
  logic        rdy_random;
  logic        req_fire;
  logic        held;
  product_t    held_prod;
  int          cycles;
  int          n_acc;
  int          n_del;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // signed product of the sign-extended operands
  function automatic product_t ref_mul(input operand_t a, input operand_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    return product_t'(sa * sb);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input product_t got, input product_t want, input string msg);
    if (got !== want) begin
      fail_run($sformatf("mismatch at %0d ns: %s, got %h, expected %h",
                         $time, msg, got, want));
    end
  endtask

  task automatic push_req(input operand_t a, input operand_t b);
    req_q.push_back({a, b});
  endtask

  // returns on a falling edge once every request has come back
  task automatic wait_drained();
    do begin
      @(negedge clk);
    end while (req_q.size() != 0 || req_val || n_del != n_acc);
  endtask

  // ------------------------------------------------------------------------
  // clock, DUT
  // ------------------------------------------------------------------------

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  imul_top dut (
    .clk          (clk),
    .reset        (reset),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_product (resp_product),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  // ------------------------------------------------------------------------
  // drivers on the falling edge
  // ------------------------------------------------------------------------

  // request stays on the bus until the handshake edge
  initial begin
    req_val = 1'b0;
    req_a   = '0;
    req_b   = '0;
    forever begin
      @(negedge clk);
      if (req_fire) begin
        req_val = 1'b0;
      end
      if (!req_val && !reset && req_q.size() != 0) begin
        {req_a, req_b} = req_q.pop_front();
        req_val = 1'b1;
      end
    end
  end

  initial begin
    resp_rdy = 1'b1;
    forever begin
      @(negedge clk);
      if (rdy_random) begin
        lcg_state = lcg_next(lcg_state);
        // ready about one cycle in 32 so long stalls fill both slots
        resp_rdy = (lcg_state[31:27] == 5'd0);
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // monitor, compare and timeout
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      // with two multiplies held the input side must be closed
      if (n_acc - n_del > 2) begin
        fail_run("more than two multiplies in flight");
      end
      if (n_acc - n_del == 2) begin
        check(product_t'(req_rdy), '0, "req_rdy with two multiplies in flight");
      end
      if (held) begin
        check(resp_product, held_prod, "resp_product changed under back-pressure");
      end
      if (resp_val && resp_rdy) begin
        n_del = n_del + 1;
      end
    end
    held      = !reset && resp_val && !resp_rdy;
    held_prod = resp_product;
    req_fire  = !reset && req_val && req_rdy;
    if (req_fire) begin
      exp_q.push_back(ref_mul(req_a, req_b));
      acc_t_q.push_back($time);
      n_acc = n_acc + 1;
    end
  end

  always @(posedge clk) begin
    product_t want;
    time      lat;
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        fail_run("response delivered with no request outstanding");
      end else begin
        want = exp_q.pop_front();
        lat  = $time - acc_t_q.pop_front();
        check(resp_product, want, "product");
        // resp_val is first seen one edge after it is set
        if (!rdy_random) begin
          check(lat, (latency + 1) * clk_period, "accept to resp_val latency");
          check(product_t'(req_rdy), 64'd1, "req_rdy when the response appears");
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    operand_t a_r;
    operand_t b_r;
    reset      = 1'b1;
    lcg_state  = seed;
    rdy_random = 1'b0;
    cycles     = 0;
    n_acc      = 0;
    n_del      = 0;
    held       = 1'b0;
    req_fire   = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    check(product_t'(req_rdy), 64'd1, "req_rdy after reset");
    check(product_t'(resp_val), '0, "resp_val after reset");
    check(ref_mul(32'h8000_0000, 32'h8000_0000), 64'h4000_0000_0000_0000,
          "reference for -2^31 squared");

    // directed corners are pushed on a rising edge so the driver sees them next
    @(posedge clk);
    push_req(32'h0000_0000, 32'h1234_5678);
    push_req(32'h8765_4321, 32'h0000_0000);
    push_req(32'h0000_0001, 32'hffff_ffff);
    push_req(32'hffff_ffff, 32'hffff_ffff);
    push_req(32'h7fff_ffff, 32'h7fff_ffff);
    push_req(32'h8000_0000, 32'h0000_0001);
    push_req(32'h8000_0000, 32'h8000_0000);
    push_req(32'h8000_0000, 32'h7fff_ffff);
    wait_drained();

    // random signed operands with the consumer always ready
    @(posedge clk);
    for (int i = 0; i < n_random; i++) begin
      lcg_state = lcg_next(lcg_state);
      a_r       = lcg_state;
      lcg_state = lcg_next(lcg_state);
      b_r       = lcg_state;
      push_req(a_r, b_r);
    end
    wait_drained();

    // random back-pressure on the response side
    @(posedge clk);
    for (int i = 0; i < n_backpr; i++) begin
      lcg_state = lcg_next(lcg_state);
      a_r       = lcg_state;
      lcg_state = lcg_next(lcg_state);
      b_r       = lcg_state;
      push_req(a_r, b_r);
    end
    rdy_random = 1'b1;
    wait_drained();

    if (exp_q.size() == 0 && n_acc == n_ops && n_del == n_ops) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run($sformatf("lost or extra responses: %0d accepted, %0d delivered",
                         n_acc, n_del));
    end
  end

endmodule

// File: flist.f
common/imul_pkg.sv
rtl/imul_req_stage.sv
imul_iter/imul_iter_ctrl.sv
imul_iter/imul_iter_dpath.sv
rtl/imul_resp_stage.sv
rtl/imul_top.sv
tb/imul_tb.sv

// File: Bender.yml
package:
  name: imul

sources:
  # shared package
  - common/imul_pkg.sv
  # iterative core
  - imul_iter/imul_iter_ctrl.sv
  - imul_iter/imul_iter_dpath.sv
  # request and response stages, top level
  - rtl/imul_req_stage.sv
  - rtl/imul_resp_stage.sv
  - rtl/imul_top.sv
  # testbench
  - target: simulation
    files:
      - tb/imul_tb.sv
